//--- src.f
common/loader_pkg.sv
src/reset_sequencer.sv
loader/word_assembler.sv
loader/slot_writer.sv
loader/image_classifier.sv
src/mem_port_mux.sv
src/image_loader_top.sv
dv/tb_clock_gen.sv
dv/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the image loader testbench with Verilator, run it, and check the log

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f src.f -o tb_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
	echo "Simulation result: pass"
	exit 0
else
	echo "Simulation result: fail"
	exit 1
fi

//--- dv/tb_top.sv
// Directed testbench for the image loader with test tasks, write monitor and error counting
`timescale 1ns/100ps

module tb_top;

	logic                         clk_sys;
	logic                         rst;
	logic                         clk8_en = 1'b0;
	logic                         dl_slot = 1'b0;
	logic                         reset_req;
	logic                         cpu_reset;
	logic                         cfg_mem;
	logic [1:0]                   cfg_cpu;
	logic                         sys_run;
	logic                         host_download;
	logic [7:0]                   host_index;
	logic                         host_wr;
	logic [24:0]                  host_addr;
	logic [7:0]                   host_data;
	logic                         host_wait;
	logic [1:0]                   disk_eject;
	loader_pkg::disk_kind_t [1:0] disk_state;
	logic [1:0]                   disk_inserted;
	loader_pkg::cpu_mem_t         cpu_req;
	logic [15:0]                  mem_rdata;
	logic                         disk_ack;
	loader_pkg::mem_req_t         mem_req;
	logic [15:0]                  cpu_rdata;

	int          errors = 0;
	int          timeouts = 0;
	integer      seed = 9889;
	logic [1:0]  en_cnt = 2'd0;
	logic [3:0]  slot_cnt = 4'd0;
	logic        slot_prev = 1'b0;
	logic [40:0] write_log[$];

	tb_clock_gen u_clock_gen (
		.clk_sys (clk_sys),
		.rst     (rst)
	);

	image_loader_top u_dut (.*);

	// 8 MHz enable every 4th cycle and arbiter slot 4 cycles out of 16
	always @(posedge clk_sys) begin
		en_cnt   <= en_cnt + 2'd1;
		slot_cnt <= slot_cnt + 4'd1;
		clk8_en  <= (en_cnt == 2'd3);
		dl_slot  <= (slot_cnt >= 4'd12);
	end

	// Logs address and data once per download slot that carries a write
	always @(negedge clk_sys) begin
		if (dl_slot && !slot_prev && host_download && mem_req.we) begin
			write_log.push_back({mem_req.addr, mem_req.wdata});
		end
		slot_prev = dl_slot;
	end

	// ==================================================
	// Helpers
	// ==================================================
	task automatic report_mismatch(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		errors++;
		$display("Fail %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timed out at %0t waiting for %s", $time, what);
	endtask

	// Memory word address of a download byte from region, image index and word offset
	function automatic logic [24:0] dl_mem_addr(input logic [1:0] idx,
			input logic [24:0] byte_addr);
		dl_mem_addr = {4'd1, idx, byte_addr[19:1]};
	endfunction

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		host_wr   <= 1'b1;
		host_addr <= addr;
		host_data <= data;
		@(posedge clk_sys);
		host_wr <= 1'b0;
	endtask

	task automatic await_host_wait(input logic level, input int limit, input string what);
		int cyc;
		cyc = 0;
		@(negedge clk_sys);
		while (host_wait !== level && cyc < limit) begin
			@(negedge clk_sys);
			cyc++;
		end
		if (host_wait !== level) report_timeout(what);
	endtask

	task automatic await_sys_run(input logic level, input int limit, input string what);
		int cyc;
		cyc = 0;
		@(negedge clk_sys);
		while (sys_run !== level && cyc < limit) begin
			@(negedge clk_sys);
			cyc++;
		end
		if (sys_run !== level) report_timeout(what);
	endtask

	// Ends a download with the image length left on the address bus
	task automatic end_download(input logic [7:0] index, input logic [24:0] length);
		@(posedge clk_sys);
		host_index    <= index;
		host_addr     <= length;
		host_download <= 1'b1;
		repeat (2) @(posedge clk_sys);
		host_download <= 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_drives(input loader_pkg::disk_kind_t exp0,
			input loader_pkg::disk_kind_t exp1, input string what);
		logic [1:0] exp_ins;
		exp_ins = {exp1 != loader_pkg::DISK_NONE, exp0 != loader_pkg::DISK_NONE};
		if (disk_state[0] !== exp0) report_mismatch({what, " drive 0"}, disk_state[0], exp0);
		if (disk_state[1] !== exp1) report_mismatch({what, " drive 1"}, disk_state[1], exp1);
		if (disk_inserted !== exp_ins)
			report_mismatch({what, " inserted"}, disk_inserted, exp_ins);
	endtask

	// ==================================================
	// Tests
	// ==================================================
	task automatic check_reset_release();
		int ticks;
		int cyc;
		ticks = 0;
		cyc = 0;
		if (sys_run !== 1'b0) report_mismatch("sys_run after reset", sys_run, 0);
		while (sys_run !== 1'b1 && cyc < 5000) begin
			if (clk8_en) ticks++;
			@(negedge clk_sys);
			cyc++;
		end
		if (sys_run !== 1'b1) begin
			report_timeout("sys_run to rise after reset");
		end else if (ticks < 1023 || ticks > 1030) begin
			report_mismatch("enable ticks until sys_run", ticks, 1023);
		end
		// A config change restarts the release delay
		@(posedge clk_sys);
		cfg_mem <= 1'b1;
		await_sys_run(1'b0, 16, "sys_run to drop after a cfg_mem change");
	endtask

	task automatic single_download_write();
		logic [7:0] hi;
		logic [7:0] lo;
		int         cyc;
		hi = 8'($random(seed));
		lo = 8'($random(seed));
		@(posedge clk_sys);
		host_download <= 1'b1;
		host_index    <= 8'd2;
		send_byte(25'd6, hi);
		send_byte(25'd7, lo);
		await_host_wait(1'b1, 8, "host_wait after the odd byte");
		cyc = 0;
		while (!(dl_slot && mem_req.we) && cyc < 40) begin
			@(negedge clk_sys);
			cyc++;
		end
		if (!(dl_slot && mem_req.we)) begin
			report_timeout("a write in a download slot");
		end else begin
			if (mem_req.addr !== {4'd1, 2'd2, 19'd3})
				report_mismatch("download address", mem_req.addr, {4'd1, 2'd2, 19'd3});
			if (mem_req.wdata !== {hi, lo})
				report_mismatch("download data", mem_req.wdata, {hi, lo});
			if (mem_req.be !== 2'b11) report_mismatch("download byte enables", mem_req.be, 2'b11);
			if (mem_req.oe !== 1'b0) report_mismatch("download output enable", mem_req.oe, 0);
		end
		await_host_wait(1'b0, 40, "host_wait to fall after the slot");
		@(posedge clk_sys);
		host_download <= 1'b0;
	endtask

	task automatic stream_backpressure();
		logic [40:0] sent[$];
		logic [24:0] addr;
		logic [15:0] data;
		@(posedge clk_sys);
		host_download <= 1'b1;
		host_index    <= 8'd1;
		write_log.delete();
		for (int i = 0; i < 20; i++) begin
			addr = 25'h200 + 25'(2 * i);
			data = 16'($random(seed));
			send_byte(addr, data[15:8]);
			send_byte(addr | 25'd1, data[7:0]);
			sent.push_back({dl_mem_addr(2'd1, addr), data});
			await_host_wait(1'b1, 8, "host_wait after a streamed word");
			await_host_wait(1'b0, 40, "host_wait release in the stream");
		end
		@(posedge clk_sys);
		host_download <= 1'b0;
		if (write_log.size() != 20) report_mismatch("stream write count", write_log.size(), 20);
		for (int i = 0; i < 20 && i < write_log.size(); i++) begin
			if (write_log[i] !== sent[i])
				report_mismatch($sformatf("stream write %0d", i), write_log[i], sent[i]);
		end
	endtask

	task automatic classify_images();
		end_download(8'd1, 25'd819200);
		check_drives(loader_pkg::DISK_DS, loader_pkg::DISK_NONE, "internal double sided");
		end_download(8'd2, 25'd409600);
		check_drives(loader_pkg::DISK_DS, loader_pkg::DISK_SS, "external single sided");
		end_download(8'd1, 25'd12346);
		check_drives(loader_pkg::DISK_NONE, loader_pkg::DISK_SS, "odd length");
		end_download(8'd1, 25'd819200);
		end_download(8'd0, 25'd196608);
		check_drives(loader_pkg::DISK_DS, loader_pkg::DISK_SS, "ROM download");
		@(posedge clk_sys);
		disk_eject <= 2'b10;
		@(posedge clk_sys);
		disk_eject <= 2'b00;
		repeat (2) @(negedge clk_sys);
		check_drives(loader_pkg::DISK_DS, loader_pkg::DISK_NONE, "eject drive 1");
	endtask

	task automatic cpu_path_shaping();
		loader_pkg::cpu_mem_t req;
		logic [15:0]          rdata;
		logic [7:0]           sel;
		int                   cyc;
		for (int i = 0; i < 8; i++) begin
			req.addr  = 22'($random(seed));
			req.wdata = 16'($random(seed));
			{req.rom_sel, req.ram_oe, req.ram_we, req.uds, req.lds} = 5'($random(seed));
			// Floppy reads alternate between the high and the low byte
			req.addr[0] = i[1];
			rdata = 16'($random(seed));
			@(posedge clk_sys);
			cpu_req   <= req;
			mem_rdata <= rdata;
			disk_ack  <= i[0];
			@(negedge clk_sys);
			if (mem_req.addr !== {3'b000, req.rom_sel, req.addr[21:1]})
				report_mismatch("CPU address", mem_req.addr, {3'b000, req.rom_sel, req.addr[21:1]});
			if (mem_req.wdata !== req.wdata)
				report_mismatch("CPU data", mem_req.wdata, req.wdata);
			if (mem_req.be !== {req.uds, req.lds})
				report_mismatch("CPU byte enables", mem_req.be, {req.uds, req.lds});
			if (mem_req.we !== req.ram_we) report_mismatch("CPU write", mem_req.we, req.ram_we);
			if (mem_req.oe !== (req.ram_oe | req.rom_sel))
				report_mismatch("CPU output enable", mem_req.oe, req.ram_oe | req.rom_sel);
			// Floppy reads repeat one byte and an odd address picks the low one
			sel = req.addr[0] ? rdata[7:0] : rdata[15:8];
			if (i[0] && cpu_rdata !== {sel, sel})
				report_mismatch("floppy read", cpu_rdata, {sel, sel});
			if (!i[0] && cpu_rdata !== rdata) report_mismatch("plain read", cpu_rdata, rdata);
		end
		@(posedge clk_sys);
		host_index    <= 8'd0;
		host_download <= 1'b1;
		cyc = 0;
		@(negedge clk_sys);
		while (!dl_slot && cyc < 20) begin
			@(negedge clk_sys);
			cyc++;
		end
		if (!dl_slot) begin
			report_timeout("a download slot for the read check");
		end else if (cpu_rdata !== 16'hffff) begin
			report_mismatch("read during download slot", cpu_rdata, 16'hffff);
		end
		@(posedge clk_sys);
		host_download <= 1'b0;
	endtask

	initial begin
		int cyc;
		reset_req     = 1'b0;
		cpu_reset     = 1'b0;
		cfg_mem       = 1'b0;
		cfg_cpu       = 2'd0;
		host_download = 1'b0;
		host_index    = 8'd0;
		host_wr       = 1'b0;
		host_addr     = 25'd0;
		host_data     = 8'd0;
		disk_eject    = 2'b00;
		cpu_req       = '0;
		mem_rdata     = 16'd0;
		disk_ack      = 1'b0;
		cyc = 0;
		@(negedge clk_sys);
		while (rst !== 1'b0 && cyc < 20) begin
			@(negedge clk_sys);
			cyc++;
		end
		if (rst !== 1'b0) report_timeout("reset release");
		check_reset_release();
		single_download_write();
		stream_backpressure();
		classify_images();
		cpu_path_shaping();
		$display("Test summary: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- dv/tb_clock_gen.sv
// Testbench clock source with 10 ns period and power-on reset
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Reset held for the first 10 rising edges
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk_sys);
		rst <= 1'b0;
	end

endmodule

//--- src/image_loader_top.sv
// Image loader top level: byte pairing, slot writes, image sizing, memory mux and reset release
`timescale 1ns/100ps

module image_loader_top (
	input  logic                               clk_sys,
	input  logic                               rst,
	input  logic                               clk8_en,
	input  logic                               reset_req,
	input  logic                               cpu_reset,
	input  logic                               cfg_mem,
	input  logic [1:0]                         cfg_cpu,
	output logic                               sys_run,
	input  logic                               host_download,
	input  logic [7:0]                         host_index,
	input  logic                               host_wr,
	input  logic [loader_pkg::HOST_ADDR_W-1:0] host_addr,
	input  logic [loader_pkg::BYTE_W-1:0]      host_data,
	output logic                               host_wait,
	input  logic                               dl_slot,
	input  logic [1:0]                         disk_eject,
	output loader_pkg::disk_kind_t [1:0]       disk_state,
	output logic [1:0]                         disk_inserted,
	input  loader_pkg::cpu_mem_t               cpu_req,
	input  logic [loader_pkg::WORD_W-1:0]      mem_rdata,
	input  logic                               disk_ack,
	output loader_pkg::mem_req_t               mem_req,
	output logic [loader_pkg::WORD_W-1:0]      cpu_rdata
);

	loader_pkg::dl_word_t word;
	logic                 word_valid;
	loader_pkg::dl_word_t dl_word;
	logic                 dl_we;

	reset_sequencer u_reset_sequencer (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.clk8_en   (clk8_en),
		.reset_req (reset_req),
		.cpu_reset (cpu_reset),
		.cfg_mem   (cfg_mem),
		.cfg_cpu   (cfg_cpu),
		.sys_run   (sys_run)
	);

	// Download path
	word_assembler u_word_assembler (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.host_wr    (host_wr),
		.host_addr  (host_addr),
		.host_data  (host_data),
		.host_index (host_index),
		.word       (word),
		.word_valid (word_valid)
	);

	slot_writer u_slot_writer (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.word       (word),
		.word_valid (word_valid),
		.dl_slot    (dl_slot),
		.dl_word    (dl_word),
		.dl_we      (dl_we),
		.host_wait  (host_wait)
	);

	image_classifier u_image_classifier (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.host_download (host_download),
		.host_index    (host_index),
		.host_addr     (host_addr),
		.disk_eject    (disk_eject),
		.disk_state    (disk_state),
		.disk_inserted (disk_inserted)
	);

	mem_port_mux u_mem_port_mux (
		.host_download (host_download),
		.dl_slot       (dl_slot),
		.dl_word       (dl_word),
		.dl_we         (dl_we),
		.cpu_req       (cpu_req),
		.mem_rdata     (mem_rdata),
		.disk_ack      (disk_ack),
		.mem_req       (mem_req),
		.cpu_rdata     (cpu_rdata)
	);

endmodule

//--- src/mem_port_mux.sv
// Memory port multiplexer: download versus CPU request selection and CPU read data shaping
`timescale 1ns/100ps

module mem_port_mux (
	input  logic                             host_download,
	input  logic                             dl_slot,
	input  loader_pkg::dl_word_t             dl_word,
	input  logic                             dl_we,
	input  loader_pkg::cpu_mem_t             cpu_req,
	input  logic [loader_pkg::WORD_W-1:0]    mem_rdata,
	input  logic                             disk_ack,
	output loader_pkg::mem_req_t             mem_req,
	output logic [loader_pkg::WORD_W-1:0]    cpu_rdata
);

	logic                                download_cycle;
	logic [loader_pkg::BYTE_W-1:0]       disk_byte;

	// Arbiter slot only counts while a download is running
	assign download_cycle = host_download && dl_slot;

	// ==================================================
	// Request side
	// ==================================================
	always_comb begin
		if (download_cycle) begin
			mem_req.addr  = {loader_pkg::DL_REGION, dl_word.addr};
			mem_req.wdata = dl_word.data;
			mem_req.be    = 2'b11;
			mem_req.we    = dl_we;
			mem_req.oe    = 1'b0;
		end else begin
			// ROM sits one bit above the RAM word space
			mem_req.addr  = {3'b000, cpu_req.rom_sel, cpu_req.addr[loader_pkg::CPU_ADDR_W-1:1]};
			mem_req.wdata = cpu_req.wdata;
			mem_req.be    = {cpu_req.uds, cpu_req.lds};
			mem_req.we    = cpu_req.ram_we;
			mem_req.oe    = cpu_req.ram_oe || cpu_req.rom_sel;
		end
	end

	// ==================================================
	// Read side
	// ==================================================

	// Floppy reads are byte wide, odd address takes the low byte
	assign disk_byte = cpu_req.addr[0] ? mem_rdata[7:0] : mem_rdata[15:8];

	always_comb begin
		if (download_cycle) begin
			// All ones keeps the screen dark while loading
			cpu_rdata = '1;
		end else if (disk_ack) begin
			cpu_rdata = {disk_byte, disk_byte};
		end else begin
			cpu_rdata = mem_rdata;
		end
	end

endmodule

//--- loader/image_classifier.sv
// Image classifier: sizes floppy images at download end and tracks drive eject
`timescale 1ns/100ps

module image_classifier (
	input  logic                                clk_sys,
	input  logic                                rst,
	input  logic                                host_download,
	input  logic [7:0]                          host_index,
	input  logic [loader_pkg::HOST_ADDR_W-1:0]  host_addr,
	input  logic [1:0]                          disk_eject,
	output loader_pkg::disk_kind_t [1:0]        disk_state,
	output logic [1:0]                          disk_inserted
);

	logic                               download_q;
	logic                               download_end;
	logic [loader_pkg::HOST_ADDR_W-1:0] img_words;

	// Host leaves the byte length on the address bus when it finishes
	assign download_end = download_q && !host_download;
	assign img_words    = host_addr >> 1;

	function automatic loader_pkg::disk_kind_t classify(
		input logic [loader_pkg::HOST_ADDR_W-1:0] words
	);
		if (words == loader_pkg::IMG_WORDS_DS) begin
			classify = loader_pkg::DISK_DS;
		end else if (words == loader_pkg::IMG_WORDS_SS) begin
			classify = loader_pkg::DISK_SS;
		end else begin
			// Unknown size, treat as no disk
			classify = loader_pkg::DISK_NONE;
		end
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			download_q <= 1'b0;
			disk_state <= {loader_pkg::DISK_NONE, loader_pkg::DISK_NONE};
		end else begin
			download_q <= host_download;

			if (download_end) begin
				case (host_index)
					loader_pkg::IDX_INT: disk_state[0] <= classify(img_words);
					loader_pkg::IDX_EXT: disk_state[1] <= classify(img_words);
					// ROM image leaves both drives alone
					loader_pkg::IDX_ROM: ;
					default: ;
				endcase
			end

			// Eject wins over a download ending in the same cycle
			for (int i = 0; i < 2; i++) begin
				if (disk_eject[i]) begin
					disk_state[i] <= loader_pkg::DISK_NONE;
				end
			end
		end
	end

	assign disk_inserted[0] = disk_state[0] != loader_pkg::DISK_NONE;
	assign disk_inserted[1] = disk_state[1] != loader_pkg::DISK_NONE;

endmodule

//--- loader/slot_writer.sv
// Slot writer: holds one pending word, drives host back-pressure, writes it in one download slot
`timescale 1ns/100ps

module slot_writer (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  loader_pkg::dl_word_t word,
	input  logic                 word_valid,
	input  logic                 dl_slot,
	output loader_pkg::dl_word_t dl_word,
	output logic                 dl_we,
	output logic                 host_wait
);

	// Slot level from the previous cycle, for edge detection
	logic slot_q;
	logic slot_fall;

	assign slot_fall = slot_q && !dl_slot;

	// Pending word register
	always_ff @(posedge clk_sys) begin
		if (word_valid) begin
			dl_word <= word;
		end
	end

	// ==================================================
	// Write control
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			slot_q    <= 1'b0;
			dl_we     <= 1'b0;
			host_wait <= 1'b0;
		end else begin
			slot_q <= dl_slot;

			// Write enable only moves outside a slot so it is steady across a whole slot
			if (!dl_slot) begin
				dl_we <= host_wait;
			end

			// Host stalls as soon as a word is pending
			if (word_valid) begin
				host_wait <= 1'b1;
			end else if (slot_fall && dl_we) begin
				// Slot just ended with our write in it, word is done
				host_wait <= 1'b0;
			end
		end
	end

endmodule

//--- loader/word_assembler.sv
// Word assembler: pairs host bytes into 16-bit words and builds the download word address
`timescale 1ns/100ps

module word_assembler (
	input  logic                               clk_sys,
	input  logic                               rst,
	input  logic                               host_wr,
	input  logic [loader_pkg::HOST_ADDR_W-1:0] host_addr,
	input  logic [loader_pkg::BYTE_W-1:0]      host_data,
	input  logic [7:0]                         host_index,
	output loader_pkg::dl_word_t               word,
	output logic                               word_valid
);

	// Even byte waits here until its odd partner arrives
	logic [loader_pkg::BYTE_W-1:0] hi_byte;
	logic                          odd_byte;

	assign odd_byte = host_addr[0];

	// ==================================================
	// Byte pairing
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (host_wr && !odd_byte) begin
			hi_byte <= host_data;
		end

		if (host_wr && odd_byte) begin
			// Big endian pairing, first byte is the upper half
			word.data <= {hi_byte, host_data};
			// Image index selects the 512K word window, byte address gives the offset
			word.addr <= {host_index[1:0], host_addr[loader_pkg::DL_OFFS_W:1]};
		end
	end

	// One-cycle strobe per completed word
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			word_valid <= 1'b0;
		end else begin
			word_valid <= host_wr && odd_byte;
		end
	end

endmodule

//--- src/reset_sequencer.sv
// Reset sequencer: gathers reset sources and config changes, delays the system run release
`timescale 1ns/100ps

module reset_sequencer (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       clk8_en,
	input  logic       reset_req,
	input  logic       cpu_reset,
	input  logic       cfg_mem,
	input  logic [1:0] cfg_cpu,
	output logic       sys_run
);

	logic [loader_pkg::RESET_CNT_W-1:0] cnt;
	logic                               cfg_mem_q;
	logic [1:0]                         cfg_cpu_q;
	logic                               cfg_change;
	logic                               hold;

	// Config is compared against the sample from the previous tick
	assign cfg_change = clk8_en && ((cfg_mem != cfg_mem_q) || (cfg_cpu != cfg_cpu_q));

	// Direct sources act on any cycle so short pulses are not lost between ticks
	assign hold = reset_req || cpu_reset || cfg_change;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt       <= '1;
			sys_run   <= 1'b0;
			cfg_mem_q <= 1'b0;
			cfg_cpu_q <= 2'd0;
		end else begin
			if (clk8_en) begin
				cfg_mem_q <= cfg_mem;
				cfg_cpu_q <= cfg_cpu;
			end

			if (hold) begin
				// Restart the full release delay
				cnt     <= '1;
				sys_run <= 1'b0;
			end else if (clk8_en) begin
				if (cnt != '0) begin
					cnt <= cnt - 1'b1;
				end else begin
					sys_run <= 1'b1;
				end
			end
		end
	end

endmodule

//--- common/loader_pkg.sv
// Loader package with bus widths, image sizes, region and index codes, shared struct types
package loader_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int WORD_W      = 16;
	localparam int BYTE_W      = 8;
	localparam int HOST_ADDR_W = 25;
	localparam int CPU_ADDR_W  = 22;
	localparam int MEM_ADDR_W  = 25;
	localparam int RESET_CNT_W = 10;

	// Download word address is image index (2 bits) over word offset (19 bits)
	localparam int DL_ADDR_W = 21;
	localparam int DL_OFFS_W = 19;

	// Download images live above this 4-bit prefix in memory
	localparam logic [3:0] DL_REGION = 4'd1;

	// ==================================================
	// Floppy image sizes, counted in 16-bit words
	// ==================================================
	localparam int unsigned IMG_WORDS_DS = 409600;
	localparam int unsigned IMG_WORDS_SS = 204800;

	// Host image index values
	localparam logic [7:0] IDX_ROM = 8'd0;
	localparam logic [7:0] IDX_INT = 8'd1;
	localparam logic [7:0] IDX_EXT = 8'd2;

	// ==================================================
	// Shared types
	// ==================================================
	typedef struct packed {
		logic [DL_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]    data;
	} dl_word_t;

	// CPU side memory request, all controls active high
	typedef struct packed {
		logic [CPU_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     wdata;
		logic                  rom_sel;
		logic                  ram_oe;
		logic                  ram_we;
		logic                  uds;
		logic                  lds;
	} cpu_mem_t;

	// Request toward external memory
	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic [WORD_W-1:0]     wdata;
		logic [1:0]            be;
		logic                  we;
		logic                  oe;
	} mem_req_t;

	typedef enum logic [1:0] {
		DISK_NONE,
		DISK_SS,
		DISK_DS
	} disk_kind_t;

endpackage
